//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = exec_cluster_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
PASS_MSG = Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass message shows up in the simulator output
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
+incdir+sim
source/exec_isa_pkg.sv
source/exec_stream_pkg.sv
source/rr_arbiter.sv
source/skid_buffer.sv
source/stream_mux.sv
source/exec_decode.sv
source/exec_alu.sv
source/result_router.sv
source/exec_cluster_top.sv
sim/exec_cluster_tb.sv

//--- sim/exec_cluster_vectors.svh
`ifndef EXEC_CLUSTER_VECTORS_SVH
`define EXEC_CLUSTER_VECTORS_SVH

typedef struct packed {
    logic [1:0]  req_id;    // Issuing requester
    logic [15:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [7:0]  tag;
    logic [31:0] expected;
} vec_t;

localparam int NUM_DIRECTED = 18;
localparam int NUM_RANDOM   = 48;
localparam int TABLE_LEN    = NUM_DIRECTED + NUM_RANDOM;

// requester, instruction, operand a, operand b, tag, expected result
// Entry 0 runs alone, entries 14 to 17 use one requester each
localparam vec_t DIRECTED [NUM_DIRECTED] = '{
    '{2'd2, 16'h0000, 32'h0000_0005, 32'h0000_0007, 8'h01, 32'h0000_000C},
    '{2'd0, 16'h1000, 32'h0000_0003, 32'h0000_0005, 8'h02, 32'hFFFF_FFFE},
    '{2'd1, 16'h2000, 32'hF0F0_F0F0, 32'hFF00_FF00, 8'h03, 32'hF000_F000},
    '{2'd2, 16'h3000, 32'hF0F0_0000, 32'h0F0F_0000, 8'h04, 32'hFFFF_0000},
    '{2'd3, 16'h4000, 32'hAAAA_5555, 32'hFFFF_FFFF, 8'h05, 32'h5555_AAAA},
    '{2'd0, 16'h5000, 32'h0000_0001, 32'h0000_0024, 8'h06, 32'h0000_0010},
    '{2'd0, 16'h5008, 32'h0000_00FF, 32'h0000_0003, 8'h07, 32'h0000_FF00},
    '{2'd1, 16'h5020, 32'h0000_00AB, 32'h0000_0003, 8'h08, 32'h0000_00AB},
    '{2'd1, 16'h6004, 32'h8000_0000, 32'h0000_001F, 8'h09, 32'h0800_0000},
    '{2'd2, 16'h6000, 32'h8000_0000, 32'h0000_001F, 8'h0A, 32'h0000_0001},
    '{2'd3, 16'h7000, 32'hFFFF_FFFF, 32'h0000_0001, 8'h0B, 32'h0000_0001},
    '{2'd3, 16'h7000, 32'h0000_0005, 32'hFFFF_FFFE, 8'h0C, 32'h0000_0000},
    '{2'd0, 16'h8FFF, 32'h0000_000A, 32'h1234_5678, 8'h0D, 32'h0000_0009},
    '{2'd2, 16'h87FF, 32'h0000_0001, 32'h0000_0000, 8'h0E, 32'h0000_0800},
    '{2'd1, 16'h9800, 32'hFFFF_FFFF, 32'h0000_0000, 8'h0F, 32'hFFFF_F800},
    '{2'd3, 16'hA0F0, 32'h0000_0F00, 32'h0000_0000, 8'h10, 32'h0000_0FF0},
    '{2'd0, 16'hBFFF, 32'h1234_5678, 32'h0000_0000, 8'h11, 32'hEDCB_A987},
    '{2'd2, 16'h7000, 32'h8000_0000, 32'h7FFF_FFFF, 8'h12, 32'h0000_0001}
};

logic [15:0] lfsr_state = 16'd89;

// Fibonacci LFSR, taps 16 14 13 11
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
        v = {v[30:0], lfsr_bit()};
    return v;
endfunction

function automatic logic [31:0] ref_result(input logic [15:0] instr,
                                           input logic [31:0] a, input logic [31:0] b);
    logic [31:0] imm;
    logic [4:0]  sh;
    logic [31:0] res;
    imm = {{20{instr[11]}}, instr[11:0]};
    sh  = (instr[5:0] != 6'd0) ? instr[4:0] : b[4:0];  // Override only if nonzero
    case (instr[15:12])
        4'h0:    res = a + b;
        4'h1:    res = a - b;
        4'h2:    res = a & b;
        4'h3:    res = a | b;
        4'h4:    res = a ^ b;
        4'h5:    res = a << sh;
        4'h6:    res = a >> sh;
        4'h7:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        4'h8:    res = a + imm;
        4'h9:    res = a & imm;
        4'hA:    res = a | imm;
        4'hB:    res = a ^ imm;
        default: res = 32'd0;
    endcase
    return res;
endfunction

function automatic vec_t random_vec(input logic [7:0] tag);
    vec_t       v;
    logic [3:0] op;
    op         = 4'(rand_bits(4) % 12);  // Defined opcodes only
    v.req_id   = 2'(rand_bits(2));
    v.instr    = {op, 12'(rand_bits(12))};
    v.a        = rand_bits(32);
    v.b        = rand_bits(32);
    v.tag      = tag;
    v.expected = ref_result(v.instr, v.a, v.b);
    return v;
endfunction

`endif

//--- sim/exec_cluster_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_tb;
    localparam int NUM_REQS = 4;
    localparam int PERIOD   = 40;

    `include "exec_cluster_vectors.svh"

    logic                                      clk = 1'b0;
    logic                                      rst;
    logic [NUM_REQS-1:0]                       req_valid;
    exec_stream_pkg::exec_req_t [NUM_REQS-1:0] req;
    logic [NUM_REQS-1:0]                       req_ready;
    logic [NUM_REQS-1:0]                       rsp_valid;
    exec_stream_pkg::exec_rsp_t [NUM_REQS-1:0] rsp;
    logic [NUM_REQS-1:0]                       rsp_ready;

    vec_t                vec_tab [TABLE_LEN];
    vec_t                pend_q [NUM_REQS][$];  // Not yet driven
    vec_t                exp_q [NUM_REQS][$];   // Accepted, response outstanding
    vec_t                cur [NUM_REQS];
    logic [NUM_REQS-1:0] fired;
    int                  rsp_src_log [$];
    int                  cycle;
    int                  accept_cycle;
    int                  rsp_cycle;
    int                  last_grant;
    int                  first_src;
    bit                  random_ready;

    exec_cluster_top #(
        .NUM_REQS (NUM_REQS)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "Run stopped at time %0t", $time);
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
        abort_run($sformatf("FAIL time=%0t %s expected=%h actual=%h",
                            $time, name, exp_val, act_val));
    endtask

    function automatic exec_stream_pkg::exec_req_t to_request(input vec_t v);
        exec_stream_pkg::exec_req_t q;
        q.instr = exec_isa_pkg::instr_u'(v.instr);
        q.a     = v.a;
        q.b     = v.b;
        q.tag   = v.tag;
        return q;
    endfunction

    task automatic drive_inputs();
        for (int r = 0; r < NUM_REQS; r++) begin
            if (fired[r])
                req_valid[r] = 1'b0;
            fired[r] = 1'b0;
            if (!req_valid[r] && pend_q[r].size() != 0) begin
                cur[r]       = pend_q[r].pop_front();
                req[r]       = to_request(cur[r]);
                req_valid[r] = 1'b1;
            end
            rsp_ready[r] = random_ready ? (lfsr_bit() | lfsr_bit()) : 1'b1;  // High 3 of 4
        end
    endtask

    task automatic sample_outputs();
        vec_t e;
        for (int r = 0; r < NUM_REQS; r++) begin
            if (req_valid[r] && req_ready[r]) begin
                exp_q[r].push_back(cur[r]);
                fired[r]     = 1'b1;
                accept_cycle = cycle;
                last_grant   = r;
            end
        end
        assert ($onehot0(rsp_valid))
            else abort_run($sformatf("Several requesters got a response at once (%b)", rsp_valid));
        for (int r = 0; r < NUM_REQS; r++) begin
            if (rsp_valid[r] && rsp_ready[r]) begin
                assert (exp_q[r].size() != 0)
                    else abort_run($sformatf("Requester %0d got a response it never asked for", r));
                e = exp_q[r].pop_front();
                assert (rsp[r].tag == e.tag)
                    else value_mismatch($sformatf("rsp[%0d].tag", r), 32'(e.tag), 32'(rsp[r].tag));
                assert (rsp[r].result == e.expected)
                    else value_mismatch($sformatf("rsp[%0d].result", r), e.expected,
                                        rsp[r].result);
                rsp_src_log.push_back(r);
                rsp_cycle = cycle;
            end
        end
        cycle++;
    endtask

    task automatic step_cycle();
        @(negedge clk);
        drive_inputs();
        #(PERIOD / 4);  // Outputs settled, rising edge still ahead
        sample_outputs();
    endtask

    function automatic bit traffic_pending();
        for (int r = 0; r < NUM_REQS; r++)
            if ((req_valid[r] && !fired[r]) || pend_q[r].size() != 0 || exp_q[r].size() != 0)
                return 1'b1;
        return 1'b0;
    endfunction

    task automatic run_traffic(input bit random_rsp_ready);
        random_ready = random_rsp_ready;
        step_cycle();
        while (traffic_pending())
            step_cycle();
        repeat (4) step_cycle();  // Stray or repeated responses show up here
    endtask

    task automatic load_range(input int first, input int last);
        for (int i = first; i <= last; i++)
            pend_q[vec_tab[i].req_id].push_back(vec_tab[i]);
    endtask

    initial begin
        req_valid    = '0;
        req          = '0;
        rsp_ready    = '1;
        fired        = '0;
        rst          = 1'b1;
        random_ready = 1'b0;
        cycle        = 0;
        last_grant   = NUM_REQS - 1;  // Pointer starts at requester 0
        first_src    = 0;
        for (int i = 0; i < NUM_DIRECTED; i++)
            vec_tab[i] = DIRECTED[i];
        for (int i = NUM_DIRECTED; i < TABLE_LEN; i++)
            vec_tab[i] = random_vec(8'(i + 64));
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        assert (req_ready == '0) else value_mismatch("req_ready", 32'd0, 32'(req_ready));
        assert (rsp_valid == '0) else value_mismatch("rsp_valid", 32'd0, 32'(rsp_valid));

        // Lone request on an idle pipe
        load_range(0, 0);
        run_traffic(1'b0);
        assert (rsp_cycle - accept_cycle == 2)
            else value_mismatch("response latency", 32'd2, 32'(rsp_cycle - accept_cycle));

        load_range(1, 13);
        run_traffic(1'b0);

        // All four requesters at once, grant order read back from response order
        first_src = (last_grant + 1) % NUM_REQS;  // Priority sits after the last grant
        rsp_src_log.delete();
        load_range(14, 17);
        run_traffic(1'b0);
        assert (rsp_src_log.size() == NUM_REQS)
            else abort_run("Round-robin phase did not return one response per requester");
        for (int i = 0; i < NUM_REQS; i++)
            assert (rsp_src_log[i] == (first_src + i) % NUM_REQS)
                else value_mismatch("grant order source", 32'((first_src + i) % NUM_REQS),
                                    32'(rsp_src_log[i]));

        load_range(NUM_DIRECTED, TABLE_LEN - 1);
        run_traffic(1'b1);

        $display("Testbench passed");
        $finish;
    end

    initial begin
        #((TABLE_LEN * 20 + 200) * PERIOD);
        abort_run("Watchdog expired because not all responses arrived in time");
    end

endmodule

`default_nettype wire

//--- source/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu #(
    parameter  NUM_REQS = 4,
    localparam IDXW     = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1
) (
    input  wire                        clk,
    input  wire                        rst,

    input  wire                        uop_valid,
    input  wire exec_isa_pkg::uop_t    uop,
    input  wire [IDXW-1:0]             uop_src,
    output logic                       uop_ready,

    output logic                       rsp_valid,
    output exec_stream_pkg::exec_rsp_t rsp,
    output logic [IDXW-1:0]            rsp_src,
    input  wire                        rsp_ready
);
    logic [31:0] result;

    assign uop_ready = !rsp_valid || rsp_ready;  // Stage empty or draining

    always_comb begin
        case (uop.fn)
            exec_isa_pkg::FN_ADD: result = uop.a + uop.b;
            exec_isa_pkg::FN_SUB: result = uop.a - uop.b;
            exec_isa_pkg::FN_AND: result = uop.a & uop.b;
            exec_isa_pkg::FN_OR:  result = uop.a | uop.b;
            exec_isa_pkg::FN_XOR: result = uop.a ^ uop.b;
            exec_isa_pkg::FN_SLL: result = uop.a << uop.b[4:0];
            exec_isa_pkg::FN_SRL: result = uop.a >> uop.b[4:0];
            exec_isa_pkg::FN_SLT: result = {31'd0, $signed(uop.a) < $signed(uop.b)};
            default:              result = uop.a + uop.b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            rsp_valid <= 1'b0;
        else if (uop_ready)
            rsp_valid <= uop_valid;
    end

    always_ff @(posedge clk) begin
        if (uop_valid && uop_ready) begin
            rsp.result <= result;
            rsp.tag    <= uop.tag;
            rsp_src    <= uop_src;
        end
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp) && $stable(rsp_src))
        else $error("exec_alu: response changed while stalled");

endmodule

`default_nettype wire

//--- source/exec_cluster_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_top #(
    parameter NUM_REQS = 4,
    localparam IDXW    = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1
) (
    input  wire                                          clk,
    input  wire                                          rst,

    input  wire [NUM_REQS-1:0]                           req_valid,
    input  wire exec_stream_pkg::exec_req_t [NUM_REQS-1:0] req,
    output logic [NUM_REQS-1:0]                          req_ready,

    output logic [NUM_REQS-1:0]                          rsp_valid,
    output exec_stream_pkg::exec_rsp_t [NUM_REQS-1:0]    rsp,
    input  wire [NUM_REQS-1:0]                           rsp_ready
);
    logic                       sel_valid;
    exec_stream_pkg::exec_req_t sel_req;
    logic [IDXW-1:0]            sel_src;
    logic                       sel_ready;

    logic                       uop_valid;
    exec_isa_pkg::uop_t         uop;
    logic [IDXW-1:0]            uop_src;
    logic                       uop_ready;

    logic                       alu_rsp_valid;
    exec_stream_pkg::exec_rsp_t alu_rsp;
    logic [IDXW-1:0]            alu_rsp_src;
    logic                       alu_rsp_ready;

    stream_mux #(
        .NUM_REQS (NUM_REQS)
    ) mux (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .sel_valid (sel_valid),
        .sel_req   (sel_req),
        .sel_src   (sel_src),
        .sel_ready (sel_ready)
    );

    exec_decode #(
        .NUM_REQS (NUM_REQS)
    ) decode (
        .sel_valid (sel_valid),
        .sel_req   (sel_req),
        .sel_src   (sel_src),
        .sel_ready (sel_ready),
        .uop_valid (uop_valid),
        .uop       (uop),
        .uop_src   (uop_src),
        .uop_ready (uop_ready)
    );

    exec_alu #(
        .NUM_REQS (NUM_REQS)
    ) alu (
        .clk       (clk),
        .rst       (rst),
        .uop_valid (uop_valid),
        .uop       (uop),
        .uop_src   (uop_src),
        .uop_ready (uop_ready),
        .rsp_valid (alu_rsp_valid),
        .rsp       (alu_rsp),
        .rsp_src   (alu_rsp_src),
        .rsp_ready (alu_rsp_ready)
    );

    result_router #(
        .NUM_REQS (NUM_REQS)
    ) router (
        .rsp_valid (alu_rsp_valid),
        .rsp       (alu_rsp),
        .rsp_src   (alu_rsp_src),
        .rsp_ready (alu_rsp_ready),
        .out_valid (rsp_valid),
        .out_rsp   (rsp),
        .out_ready (rsp_ready)
    );

endmodule

`default_nettype wire

//--- source/exec_decode.sv
`timescale 1ns/1ps
`default_nettype none

module exec_decode #(
    parameter  NUM_REQS = 4,
    localparam IDXW     = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1
) (
    input  wire                             sel_valid,
    input  wire exec_stream_pkg::exec_req_t sel_req,
    input  wire [IDXW-1:0]                  sel_src,
    output logic                            sel_ready,

    output logic                            uop_valid,
    output exec_isa_pkg::uop_t              uop,
    output logic [IDXW-1:0]                 uop_src,
    input  wire                             uop_ready
);
    exec_isa_pkg::instr_u instr;
    logic                 known_op;

    assign instr     = sel_req.instr;
    assign uop_valid = sel_valid;
    assign uop_src   = sel_src;
    assign sel_ready = uop_ready;

    always_comb begin
        uop.a    = sel_req.a;
        uop.b    = sel_req.b;
        uop.tag  = sel_req.tag;
        uop.fn   = exec_isa_pkg::FN_ADD;
        known_op = 1'b1;
        if (instr.r.opcode[3]) begin
            // Immediate view
            uop.b = {{20{instr.i.imm[11]}}, instr.i.imm};
            case (instr.i.opcode)
                exec_isa_pkg::OP_ADDI: uop.fn = exec_isa_pkg::FN_ADD;
                exec_isa_pkg::OP_ANDI: uop.fn = exec_isa_pkg::FN_AND;
                exec_isa_pkg::OP_ORI:  uop.fn = exec_isa_pkg::FN_OR;
                exec_isa_pkg::OP_XORI: uop.fn = exec_isa_pkg::FN_XOR;
                default:               known_op = 1'b0;
            endcase
        end else begin
            uop.fn = exec_isa_pkg::alu_fn_e'(instr.r.opcode[2:0]);
            if ((instr.r.opcode == exec_isa_pkg::OP_SLL ||
                 instr.r.opcode == exec_isa_pkg::OP_SRL) && instr.r.shamt != 6'd0)
                uop.b[4:0] = instr.r.shamt[4:0];
        end
    end

    // Checked once the inputs have settled
    always_comb begin
        if (sel_valid && uop_ready) begin
            assert final (known_op)
                else $error("exec_decode: reserved opcode %h accepted", instr.r.opcode);
        end
    end

endmodule

`default_nettype wire

//--- source/exec_isa_pkg.sv
`default_nettype none

package exec_isa_pkg;

    // Top bit set selects the immediate format
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_SLL  = 4'h5,
        OP_SRL  = 4'h6,
        OP_SLT  = 4'h7,
        OP_ADDI = 4'h8,
        OP_ANDI = 4'h9,
        OP_ORI  = 4'hA,
        OP_XORI = 4'hB
    } opcode_e;

    // Same order as the R-format opcodes
    typedef enum logic [2:0] {
        FN_ADD,
        FN_SUB,
        FN_AND,
        FN_OR,
        FN_XOR,
        FN_SLL,
        FN_SRL,
        FN_SLT
    } alu_fn_e;

    typedef struct packed {
        opcode_e     opcode;
        logic [5:0]  rsvd;
        logic [5:0]  shamt;  // Nonzero overrides operand b for SLL/SRL
    } r_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [11:0] imm;    // Signed, extended to 32 bits
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    typedef struct packed {
        alu_fn_e     fn;
        logic [31:0] a;
        logic [31:0] b;      // Already resolved from imm or override
        logic [7:0]  tag;
    } uop_t;

endpackage

`default_nettype wire

//--- source/exec_stream_pkg.sv
`default_nettype none

package exec_stream_pkg;

    // Chosen by the requester, returned as is
    typedef logic [7:0] tag_t;

    typedef struct packed {
        exec_isa_pkg::instr_u instr;
        logic [31:0]          a;
        logic [31:0]          b;
        tag_t                 tag;
    } exec_req_t;

    typedef struct packed {
        logic [31:0] result;
        tag_t        tag;
    } exec_rsp_t;

endpackage

`default_nettype wire

//--- source/result_router.sv
`timescale 1ns/1ps
`default_nettype none

module result_router #(
    parameter  NUM_REQS = 4,
    localparam IDXW     = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1
) (
    input  wire                                         rsp_valid,
    input  wire exec_stream_pkg::exec_rsp_t             rsp,
    input  wire [IDXW-1:0]                              rsp_src,
    output logic                                        rsp_ready,

    output logic [NUM_REQS-1:0]                         out_valid,
    output exec_stream_pkg::exec_rsp_t [NUM_REQS-1:0]   out_rsp,
    input  wire [NUM_REQS-1:0]                          out_ready
);
    logic [NUM_REQS-1:0] src_onehot;

    for (genvar i = 0; i < NUM_REQS; i++) begin : g_port
        assign src_onehot[i] = (rsp_src == IDXW'(i));
        assign out_rsp[i]    = rsp;  // Payload goes everywhere, valid picks the port
    end

    assign out_valid = src_onehot & {NUM_REQS{rsp_valid}};

    // Only the issuing requester can stall the pipe
    assign rsp_ready = |(out_ready & src_onehot);

endmodule

`default_nettype wire

//--- source/rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
    parameter  NUM_REQS = 4,
    localparam IDXW     = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire [NUM_REQS-1:0]  requests,
    input  wire                 unlock,
    output logic                grant_valid,
    output logic [IDXW-1:0]     grant_index,
    output logic [NUM_REQS-1:0] grant_onehot
);
    logic [IDXW-1:0] prio_ptr;
    logic            locked;
    logic [IDXW-1:0] locked_index;
    logic [IDXW-1:0] pick_index;
    logic            pick_valid;
    logic [IDXW:0]   slot;

    // Walk down so the closest request to the pointer wins
    always_comb begin
        pick_valid = |requests;
        pick_index = prio_ptr;
        slot       = '0;
        for (int i = NUM_REQS - 1; i >= 0; i--) begin
            slot = {1'b0, prio_ptr} + (IDXW+1)'(i);
            if (slot >= (IDXW+1)'(NUM_REQS))
                slot = slot - (IDXW+1)'(NUM_REQS);
            if (requests[slot[IDXW-1:0]])
                pick_index = slot[IDXW-1:0];
        end
    end

    assign grant_valid = locked || pick_valid;
    assign grant_index = locked ? locked_index : pick_index;

    always_comb begin
        grant_onehot = '0;
        if (grant_valid)
            grant_onehot[grant_index] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            locked   <= 1'b0;
            prio_ptr <= '0;
        end else if (unlock) begin
            locked   <= 1'b0;
            prio_ptr <= (grant_index == IDXW'(NUM_REQS - 1)) ? '0 : grant_index + 1'b1;
        end else if (grant_valid) begin
            locked <= 1'b1;  // Hold until the transfer fires
        end
    end

    always_ff @(posedge clk) begin
        if (!locked)
            locked_index <= pick_index;
    end

    // Grant lands on exactly one port that is asking
    a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
        grant_valid |-> $onehot(grant_onehot & requests))
        else $error("rr_arbiter: grant not one-hot on a request %b", grant_onehot);

    // Selection may not move while a handshake is pending
    a_grant_locked: assert property (@(posedge clk) disable iff (rst)
        grant_valid && !unlock |=> grant_valid && $stable(grant_index))
        else $error("rr_arbiter: grant switched before unlock");

endmodule

`default_nettype wire

//--- source/skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module skid_buffer #(
    parameter DATAW = 8
) (
    input  wire              clk,
    input  wire              rst,

    input  wire              valid_in,
    input  wire [DATAW-1:0]  data_in,
    output logic             ready_in,

    output logic             valid_out,
    output logic [DATAW-1:0] data_out,
    input  wire              ready_out
);
    logic             spare_valid;
    logic [DATAW-1:0] spare_data;
    logic [DATAW-1:0] main_data;
    logic             push;
    logic             main_open;
    logic             spare_wr;

    // Only a full spare entry stops the upstream side
    assign ready_in  = !spare_valid;
    assign push      = valid_in && ready_in;
    assign main_open = !valid_out || ready_out;  // Empty or draining this cycle
    assign spare_wr  = push && !main_open;
    assign data_out  = main_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out   <= 1'b0;
            spare_valid <= 1'b0;
        end else if (main_open) begin
            valid_out   <= spare_valid || push;
            spare_valid <= 1'b0;
        end else if (spare_wr) begin
            spare_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_open)
            main_data <= spare_valid ? spare_data : data_in;  // Spare is older
        if (spare_wr)
            spare_data <= data_in;
    end

    // A full spare keeps its entry until the main register drains
    a_spare_no_overwrite: assert property (@(posedge clk) disable iff (rst)
        spare_valid && !ready_out |=> spare_valid && $stable(spare_data))
        else $error("skid_buffer: spare written while full");

    a_spare_behind_main: assert property (@(posedge clk) disable iff (rst)
        spare_valid |-> valid_out)
        else $error("skid_buffer: spare holds data with main empty");

endmodule

`default_nettype wire

//--- source/stream_mux.sv
`timescale 1ns/1ps
`default_nettype none

module stream_mux #(
    parameter  NUM_REQS = 4,
    localparam IDXW     = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1
) (
    input  wire                                        clk,
    input  wire                                        rst,

    input  wire [NUM_REQS-1:0]                         req_valid,
    input  wire exec_stream_pkg::exec_req_t [NUM_REQS-1:0] req,
    output logic [NUM_REQS-1:0]                        req_ready,

    output logic                                       sel_valid,
    output exec_stream_pkg::exec_req_t                 sel_req,
    output logic [IDXW-1:0]                            sel_src,
    input  wire                                        sel_ready
);
    // Request travels with the index of the port it came from
    typedef struct packed {
        exec_stream_pkg::exec_req_t req;
        logic [IDXW-1:0]            src;
    } mux_pld_t;

    logic                arb_valid;
    logic [IDXW-1:0]     arb_index;
    logic [NUM_REQS-1:0] arb_onehot;
    logic                in_valid;
    logic                in_ready;
    logic                in_fire;
    mux_pld_t            in_pld;
    mux_pld_t            out_pld;

    assign in_valid  = arb_valid && req_valid[arb_index];
    assign in_fire   = in_valid && in_ready;
    assign in_pld    = '{req: req[arb_index], src: arb_index};
    assign req_ready = arb_onehot & {NUM_REQS{in_ready}};  // Granted port only

    rr_arbiter #(
        .NUM_REQS (NUM_REQS)
    ) arbiter (
        .clk          (clk),
        .rst          (rst),
        .requests     (req_valid),
        .unlock       (in_fire),
        .grant_valid  (arb_valid),
        .grant_index  (arb_index),
        .grant_onehot (arb_onehot)
    );

    skid_buffer #(
        .DATAW ($bits(mux_pld_t))
    ) out_buffer (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (in_valid),
        .data_in   (in_pld),
        .ready_in  (in_ready),
        .valid_out (sel_valid),
        .data_out  (out_pld),
        .ready_out (sel_ready)
    );

    assign sel_req = out_pld.req;
    assign sel_src = out_pld.src;

endmodule

`default_nettype wire
